// ==== test/crypt_cases.txt ====
00000100 00000200 0badc0de 00112233 44556677 8899aabb ccddeeff 0
00000110 00000300 13579bdf 01234567 89abcdef fedcba98 76543210 0
00000400 00000500 a5a5a5a5 deadbeef cafef00d 0f1e2d3c 4b5a6978 3
00000120 00000600 ffffffff 00000000 ffffffff 00000001 80000000 5
00000700 00000710 00000000 12345678 9abcdef0 0fedcba9 87654321 2
00000800 00000900 5c3e1a07 a1b2c3d4 e5f60718 293a4b5c 6d7e8f90 4
00000ff0 00000000 7f00ff00 11111111 22222222 33333333 44444444 1
00000a00 00000a10 c001d00d 0000ffff ffff0000 00ff00ff ff00ff00 5
00000b04 00000c08 3c3c3c3c 13131313 57575757 9b9b9b9b dfdfdfdf 3
00000d00 00000e00 2468ace0 f0e1d2c3 b4a59687 78695a4b 3c2d1e0f 0

// ==== files.f ====
logic/crypt_pkg.sv
logic/mem_pkg.sv
logic/cfg_decode.sv
logic/crypt_fsm.sv
logic/block_mixer.sv
logic/mem_streamer.sv
logic/crypt_top.sv
test/clk_gen.sv
test/crypt_asserts.sv
test/crypt_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then scan the log for the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module crypt_tb -o crypt_sim \
  && { ./obj_dir/crypt_sim > sim.log 2>&1; cat sim.log; } \
  && ! grep -q "FAIL: see errors above" sim.log \
  && grep -q "PASS: all tests" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== test/crypt_tb.sv ====
`timescale 1ns/1ps

module crypt_tb;

  localparam int N          = 4;
  localparam int MEM_WORDS  = 1024;
  localparam int CLEAR_CASE = 2;

  logic                         clk;
  logic                         reset_n;
  logic                         clear_i;
  logic                         cfg_we_i;
  logic [1:0]                   cfg_addr_i;
  logic [crypt_pkg::DATA_W-1:0] cfg_wdata_i;
  logic                         mem_req_o;
  logic                         mem_we_o;
  logic [mem_pkg::ADDR_W-1:0]   mem_addr_o;
  logic [crypt_pkg::DATA_W-1:0] mem_wdata_o;
  logic                         mem_gnt_i;
  logic                         mem_rvalid_i;
  logic [crypt_pkg::DATA_W-1:0] mem_rdata_i;
  logic                         busy_o;
  logic                         done_o;

  // Word addressed memory, byte address bits 11:2
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] c_src[$];
  logic [31:0] c_dst[$];
  logic [31:0] c_key[$];
  logic [31:0] c_pt[$];
  int          c_delay[$];
  int          write_cnt [N];
  logic [31:0] cur_dst;
  logic [31:0] rd_hold;
  bit          req_seen;
  bit          rd_pend;
  int          max_delay;
  int          gnt_delay;
  int          errors;
  int          cycle_limit;
  int          cycles = 0;

  clk_gen u_clk_gen (.clk_o(clk));

  crypt_top #(.N_WORDS(N)) DUT (
    .clk, .reset_n, .clear_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
    .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o,
    .mem_gnt_i, .mem_rvalid_i, .mem_rdata_i, .busy_o, .done_o
  );

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run did not end within %0d cycles", cycle_limit);
      $display("Checks done: %0d errors before the timeout", errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Whiten, rotate left by 8, then fold in the next plaintext word
  function automatic logic [31:0] expected_word(int c, int i);
    logic [31:0] t;
    t = c_pt[N * c + i] ^ c_key[c];
    return ((t << 8) | (t >> 24)) ^ c_pt[N * c + (i + 1) % N];
  endfunction

  // Falling edge, then the memory model answers the request it sees
  task automatic next_cycle();
    int widx;
    @(negedge clk);
    mem_rvalid_i = rd_pend;
    mem_rdata_i  = rd_hold;
    rd_pend      = 1'b0;
    if (mem_gnt_i || !mem_req_o) begin
      mem_gnt_i = 1'b0;
      req_seen  = 1'b0;
    end else begin
      if (!req_seen) begin
        req_seen  = 1'b1;
        gnt_delay = int'($urandom_range(max_delay, 0));
      end
      if (gnt_delay == 0) begin
        mem_gnt_i = 1'b1;
        if (mem_we_o) begin
          mem[mem_addr_o[11:2]] = mem_wdata_o;
          if (mem_addr_o < cur_dst || mem_addr_o >= cur_dst + 32'(4 * N)) begin
            errors++;
            $display("** Error at %0t: write to %h outside destination", $time, mem_addr_o);
          end else begin
            widx = int'((mem_addr_o - cur_dst) >> 2);
            write_cnt[widx]++;
          end
        end else begin
          rd_hold = mem[mem_addr_o[11:2]];
          rd_pend = 1'b1;
        end
      end else begin
        gnt_delay--;
      end
    end
  endtask

  task automatic cfg_write(logic [1:0] addr, logic [31:0] data);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    next_cycle();
    cfg_we_i = 1'b0;
  endtask

  task automatic start_run(int c);
    logic [31:0] a;
    cur_dst   = c_dst[c];
    max_delay = c_delay[c];
    for (int i = 0; i < N; i++) begin
      a = c_src[c] + 32'(4 * i);
      mem[a[11:2]] = c_pt[N * c + i];
      write_cnt[i] = 0;
    end
    cfg_write(2'd0, c_src[c]);
    cfg_write(2'd1, c_dst[c]);
    cfg_write(2'd2, c_key[c]);
    cfg_write(2'd3, 32'd1);
    while (!busy_o) next_cycle();
    // Config writes while busy must not touch this run
    cfg_write(2'd0, ~c_src[c]);
    cfg_write(2'd1, ~c_dst[c]);
    cfg_write(2'd2, ~c_key[c]);
    cfg_write(2'd3, 32'd1);
  endtask

  task automatic run_and_check(int c);
    logic [31:0] d;
    logic [31:0] s;
    start_run(c);
    while (!done_o) next_cycle();
    next_cycle();
    if (busy_o) begin
      errors++;
      $display("** Error at %0t: case %0d busy_o high after done_o", $time, c);
    end
    for (int i = 0; i < N; i++) begin
      d = c_dst[c] + 32'(4 * i);
      s = c_src[c] + 32'(4 * i);
      if (mem[d[11:2]] !== expected_word(c, i)) begin
        errors++;
        $display("** Error at %0t: case %0d word %0d got %h expected %h",
                 $time, c, i, mem[d[11:2]], expected_word(c, i));
      end
      if (write_cnt[i] != 1) begin
        errors++;
        $display("** Error at %0t: case %0d word %0d written %0d times",
                 $time, c, i, write_cnt[i]);
      end
      if (mem[s[11:2]] !== c_pt[N * c + i]) begin
        errors++;
        $display("** Error at %0t: case %0d source word %0d changed", $time, c, i);
      end
    end
  endtask

  // Abort mid-read, the following run must still be correct
  task automatic abort_run(int c);
    start_run(c);
    repeat (6) begin
      next_cycle();
      if (done_o) begin
        errors++;
        $display("** Error at %0t: done_o before the clear", $time);
      end
    end
    clear_i = 1'b1;
    next_cycle();
    clear_i = 1'b0;
    if (busy_o || done_o) begin
      errors++;
      $display("** Error at %0t: busy_o %b done_o %b after clear", $time, busy_o, done_o);
    end
  endtask

  initial begin
    int          fd;
    int          md;
    logic [31:0] s, d, k, w0, w1, w2, w3;
    reset_n      = 1'b0;
    clear_i      = 1'b0;
    cfg_we_i     = 1'b0;
    cfg_addr_i   = 2'd0;
    cfg_wdata_i  = '0;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    errors       = 0;
    max_delay    = 0;
    void'($urandom(32'hf38d23a6));
    fd = $fopen("test/crypt_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the case file test/crypt_cases.txt");
    end else begin
      while ($fscanf(fd, "%h %h %h %h %h %h %h %d\n", s, d, k, w0, w1, w2, w3, md) == 8) begin
        c_src.push_back(s);
        c_dst.push_back(d);
        c_key.push_back(k);
        c_pt.push_back(w0);
        c_pt.push_back(w1);
        c_pt.push_back(w2);
        c_pt.push_back(w3);
        c_delay.push_back(md);
      end
      $fclose(fd);
    end
    // One extra case slot covers the aborted run
    cycle_limit = 100 * (c_src.size() + 1) + 50;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = 32'hc3a5_0000 ^ 32'(i * 4);
    repeat (2) next_cycle();
    reset_n = 1'b1;
    for (int c = 0; c < c_src.size(); c++) begin
      if (c == CLEAR_CASE) abort_run(c);
      run_and_check(c);
    end
    $display("Checks done: %0d cases, %0d errors", c_src.size(), errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== test/crypt_asserts.sv ====
`timescale 1ns/1ps

module crypt_asserts (
  input logic                         clk,
  input logic                         reset_n,
  input logic                         clear_i,
  input logic                         mem_req_i,
  input logic                         mem_we_i,
  input logic [mem_pkg::ADDR_W-1:0]   mem_addr_i,
  input logic [crypt_pkg::DATA_W-1:0] mem_wdata_i,
  input logic                         mem_gnt_i,
  input logic                         rd_done_i,
  input logic                         wr_done_i,
  input logic                         done_i
);

  // Pending request holds still until granted
  req_held: assert property (@(posedge clk) disable iff (!reset_n)
    mem_req_i && !mem_gnt_i && !clear_i |=> mem_req_i && $stable(mem_we_i)
      && $stable(mem_addr_i) && $stable(mem_wdata_i))
    else $error("memory request changed before its grant");

  rd_wr_apart: assert property (@(posedge clk) disable iff (!reset_n)
    !(rd_done_i && wr_done_i))
    else $error("read and write completed in the same cycle");

  done_single: assert property (@(posedge clk) disable iff (!reset_n)
    done_i |=> !done_i)
    else $error("done_o high for two cycles");

endmodule

// The top level memory port is the streamer port
bind crypt_top crypt_asserts u_crypt_asserts (
  .clk, .reset_n, .clear_i,
  .mem_req_i(mem_req_o), .mem_we_i(mem_we_o), .mem_addr_i(mem_addr_o),
  .mem_wdata_i(mem_wdata_o), .mem_gnt_i, .rd_done_i(rd_done),
  .wr_done_i(wr_done), .done_i(done_o)
);

// ==== test/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
  parameter int HALF_NS = 4
) (
  output logic clk_o
);

  // Free running, 8 ns period with the default half period
  initial clk_o = 1'b0;

  always #(HALF_NS) clk_o = ~clk_o;

endmodule

// ==== logic/crypt_top.sv ====
`timescale 1ns/1ps

module crypt_top #(
  parameter int N_WORDS = 4,
  localparam int IDX_W = (N_WORDS > 1) ? $clog2(N_WORDS) : 1
) (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         clear_i,
  input  logic                         cfg_we_i,
  input  logic [1:0]                   cfg_addr_i,
  input  logic [crypt_pkg::DATA_W-1:0] cfg_wdata_i,
  output logic                         mem_req_o,
  output logic                         mem_we_o,
  output logic [mem_pkg::ADDR_W-1:0]   mem_addr_o,
  output logic [crypt_pkg::DATA_W-1:0] mem_wdata_o,
  input  logic                         mem_gnt_i,
  input  logic                         mem_rvalid_i,
  input  logic [crypt_pkg::DATA_W-1:0] mem_rdata_i,
  output logic                         busy_o,
  output logic                         done_o
);

  logic [mem_pkg::ADDR_W-1:0]   src_base, dst_base, rd_addr, wr_addr;
  logic [crypt_pkg::DATA_W-1:0] key, rd_data, wr_data, out_word;
  logic                         start, stream_ready, rd_req, wr_req, rd_done, wr_done;
  logic                         load_en, mix_start;
  logic [IDX_W-1:0]             load_idx, out_idx;

  cfg_decode u_cfg_decode (
    .clk, .reset_n, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
    .busy_i(busy_o), .src_base_o(src_base), .dst_base_o(dst_base),
    .key_o(key), .start_o(start)
  );

  crypt_fsm #(.N_WORDS(N_WORDS)) u_crypt_fsm (
    .clk, .reset_n, .clear_i, .start_i(start),
    .src_base_i(src_base), .dst_base_i(dst_base),
    .stream_ready_i(stream_ready), .rd_done_i(rd_done), .wr_done_i(wr_done),
    .out_word_i(out_word), .rd_req_o(rd_req), .rd_addr_o(rd_addr),
    .wr_req_o(wr_req), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
    .load_en_o(load_en), .load_idx_o(load_idx), .mix_start_o(mix_start),
    .out_idx_o(out_idx), .busy_o, .done_o
  );

  block_mixer #(.N_WORDS(N_WORDS)) u_block_mixer (
    .clk, .reset_n, .load_en_i(load_en), .load_idx_i(load_idx),
    .load_data_i(rd_data), .key_i(key), .mix_start_i(mix_start),
    .out_idx_i(out_idx), .out_word_o(out_word)
  );

  mem_streamer u_mem_streamer (
    .clk, .reset_n, .clear_i, .rd_req_i(rd_req), .rd_addr_i(rd_addr),
    .wr_req_i(wr_req), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
    .mem_gnt_i, .mem_rvalid_i, .mem_rdata_i,
    .stream_ready_o(stream_ready), .rd_done_o(rd_done), .rd_data_o(rd_data),
    .wr_done_o(wr_done), .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o
  );

endmodule

// ==== logic/mem_streamer.sv ====
`timescale 1ns/1ps

module mem_streamer (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         clear_i,
  input  logic                         rd_req_i,
  input  logic [mem_pkg::ADDR_W-1:0]   rd_addr_i,
  input  logic                         wr_req_i,
  input  logic [mem_pkg::ADDR_W-1:0]   wr_addr_i,
  input  logic [crypt_pkg::DATA_W-1:0] wr_data_i,
  input  logic                         mem_gnt_i,
  input  logic                         mem_rvalid_i,
  input  logic [crypt_pkg::DATA_W-1:0] mem_rdata_i,
  output logic                         stream_ready_o,
  output logic                         rd_done_o,
  output logic [crypt_pkg::DATA_W-1:0] rd_data_o,
  output logic                         wr_done_o,
  output logic                         mem_req_o,
  output logic                         mem_we_o,
  output logic [mem_pkg::ADDR_W-1:0]   mem_addr_o,
  output logic [crypt_pkg::DATA_W-1:0] mem_wdata_o
);

  logic rd_wait_q;
  logic accept;
  logic granted;

  // Reads take priority if both come together
  assign accept  = stream_ready_o && (rd_req_i || wr_req_i);
  assign granted = mem_req_o && mem_gnt_i;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mem_req_o <= 1'b0;
      mem_we_o  <= 1'b0;
      rd_wait_q <= 1'b0;
    end else if (clear_i) begin
      mem_req_o <= 1'b0;
      rd_wait_q <= 1'b0;
    end else if (accept) begin
      mem_req_o <= 1'b1;
      mem_we_o  <= !rd_req_i;
    end else if (granted) begin
      mem_req_o <= 1'b0;
      rd_wait_q <= !mem_we_o;
    end else if (rd_done_o) begin
      rd_wait_q <= 1'b0;
    end
  end

  // Held steady while the request waits for a grant
  always_ff @(posedge clk) begin
    if (accept) begin
      mem_addr_o  <= rd_req_i ? rd_addr_i : wr_addr_i;
      mem_wdata_o <= wr_data_i;
    end
  end

  assign stream_ready_o = !mem_req_o && !rd_wait_q;
  assign wr_done_o      = granted && mem_we_o;
  assign rd_done_o      = rd_wait_q && mem_rvalid_i;
  assign rd_data_o      = mem_rdata_i;

endmodule

// ==== logic/block_mixer.sv ====
`timescale 1ns/1ps

module block_mixer #(
  parameter int N_WORDS = 4,
  localparam int IDX_W = (N_WORDS > 1) ? $clog2(N_WORDS) : 1
) (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         load_en_i,
  input  logic [IDX_W-1:0]             load_idx_i,
  input  logic [crypt_pkg::DATA_W-1:0] load_data_i,
  input  logic [crypt_pkg::DATA_W-1:0] key_i,
  input  logic                         mix_start_i,
  input  logic [IDX_W-1:0]             out_idx_i,
  output logic [crypt_pkg::DATA_W-1:0] out_word_o
);

  localparam int DW = crypt_pkg::DATA_W;

  logic [DW-1:0] in_q  [N_WORDS];
  logic [DW-1:0] res_q [N_WORDS];

  // Whiten with the key, rotate left by 8, fold in the next word
  function automatic logic [DW-1:0] mix_word(input logic [DW-1:0] cur,
                                             input logic [DW-1:0] nxt,
                                             input logic [DW-1:0] key);
    logic [DW-1:0] t;
    t = cur ^ key;
    return {t[DW-9:0], t[DW-1:DW-8]} ^ nxt;
  endfunction

  always_ff @(posedge clk) begin
    if (load_en_i) begin
      in_q[load_idx_i] <= load_data_i;
    end
  end

  // All result words in one cycle
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < N_WORDS; i++) res_q[i] <= '0;
    end else if (mix_start_i) begin
      for (int i = 0; i < N_WORDS; i++) begin
        res_q[i] <= mix_word(in_q[i], in_q[(i + 1) % N_WORDS], key_i);
      end
    end
  end

  assign out_word_o = res_q[out_idx_i];

endmodule

// ==== logic/crypt_fsm.sv ====
`timescale 1ns/1ps

module crypt_fsm #(
  parameter int N_WORDS = 4,
  localparam int IDX_W = (N_WORDS > 1) ? $clog2(N_WORDS) : 1
) (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         clear_i,
  input  logic                         start_i,
  input  logic [mem_pkg::ADDR_W-1:0]   src_base_i,
  input  logic [mem_pkg::ADDR_W-1:0]   dst_base_i,
  input  logic                         stream_ready_i,
  input  logic                         rd_done_i,
  input  logic                         wr_done_i,
  input  logic [crypt_pkg::DATA_W-1:0] out_word_i,
  output logic                         rd_req_o,
  output logic [mem_pkg::ADDR_W-1:0]   rd_addr_o,
  output logic                         wr_req_o,
  output logic [mem_pkg::ADDR_W-1:0]   wr_addr_o,
  output logic [crypt_pkg::DATA_W-1:0] wr_data_o,
  output logic                         load_en_o,
  output logic [IDX_W-1:0]             load_idx_o,
  output logic                         mix_start_o,
  output logic [IDX_W-1:0]             out_idx_o,
  output logic                         busy_o,
  output logic                         done_o
);

  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_WORDS - 1);

  crypt_pkg::crypt_state_t state_q;
  crypt_pkg::crypt_state_t state_d;

  logic [IDX_W-1:0]           cnt_q;
  logic                       cnt_inc;
  logic [mem_pkg::ADDR_W-1:0] word_off;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= crypt_pkg::IDLE;
    end else if (clear_i) begin
      state_q <= crypt_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Word counter restarts on entry to the read and write phases
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      cnt_q <= '0;
    end else if (state_q == crypt_pkg::STARTING || state_q == crypt_pkg::WORKING) begin
      cnt_q <= '0;
    end else if (cnt_inc) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    cnt_inc = 1'b0;
    case (state_q)
      crypt_pkg::IDLE: begin
        if (start_i) state_d = crypt_pkg::STARTING;
      end
      crypt_pkg::STARTING: state_d = crypt_pkg::REQUEST_DATA;
      crypt_pkg::REQUEST_DATA: begin
        if (stream_ready_i) state_d = crypt_pkg::REQUEST_DATA_WAIT;
      end
      crypt_pkg::REQUEST_DATA_WAIT: begin
        if (rd_done_i) begin
          if (cnt_q == LAST_IDX) begin
            state_d = crypt_pkg::WORKING;
          end else begin
            state_d = crypt_pkg::REQUEST_DATA;
            cnt_inc = 1'b1;
          end
        end
      end
      // Block result is ready one cycle later
      crypt_pkg::WORKING: state_d = crypt_pkg::SEND_DATA;
      crypt_pkg::SEND_DATA: begin
        if (stream_ready_i) state_d = crypt_pkg::SEND_DATA_WAIT;
      end
      crypt_pkg::SEND_DATA_WAIT: begin
        if (wr_done_i) state_d = crypt_pkg::MEMORY_WRITE_WAIT;
      end
      crypt_pkg::MEMORY_WRITE_WAIT: begin
        if (stream_ready_i) begin
          if (cnt_q == LAST_IDX) begin
            state_d = crypt_pkg::FINISHED;
          end else begin
            state_d = crypt_pkg::SEND_DATA;
            cnt_inc = 1'b1;
          end
        end
      end
      crypt_pkg::FINISHED: state_d = crypt_pkg::IDLE;
      default: state_d = crypt_pkg::IDLE;
    endcase
  end

  // Byte offset of the current word
  assign word_off = {{(mem_pkg::ADDR_W - IDX_W){1'b0}}, cnt_q} * mem_pkg::WORD_BYTES;

  assign rd_req_o    = (state_q == crypt_pkg::REQUEST_DATA) && stream_ready_i;
  assign rd_addr_o   = src_base_i + word_off;
  assign wr_req_o    = (state_q == crypt_pkg::SEND_DATA) && stream_ready_i;
  assign wr_addr_o   = dst_base_i + word_off;
  assign wr_data_o   = out_word_i;
  assign load_en_o   = (state_q == crypt_pkg::REQUEST_DATA_WAIT) && rd_done_i;
  assign load_idx_o  = cnt_q;
  assign mix_start_o = (state_q == crypt_pkg::WORKING);
  assign out_idx_o   = cnt_q;
  assign busy_o      = (state_q != crypt_pkg::IDLE);
  assign done_o      = (state_q == crypt_pkg::FINISHED);

endmodule

// ==== logic/cfg_decode.sv ====
`timescale 1ns/1ps

module cfg_decode (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         cfg_we_i,
  input  logic [1:0]                   cfg_addr_i,
  input  logic [crypt_pkg::DATA_W-1:0] cfg_wdata_i,
  input  logic                         busy_i,
  output logic [mem_pkg::ADDR_W-1:0]   src_base_o,
  output logic [mem_pkg::ADDR_W-1:0]   dst_base_o,
  output logic [crypt_pkg::DATA_W-1:0] key_o,
  output logic                         start_o
);

  // Register map
  localparam logic [1:0] REG_SRC   = 2'd0;
  localparam logic [1:0] REG_DST   = 2'd1;
  localparam logic [1:0] REG_KEY   = 2'd2;
  localparam logic [1:0] REG_START = 2'd3;

  logic cfg_wr;

  // Config is locked from the start pulse until the run ends
  assign cfg_wr = cfg_we_i && !busy_i && !start_o;

  always_ff @(posedge clk) begin
    if (cfg_wr) begin
      case (cfg_addr_i)
        REG_SRC: src_base_o <= cfg_wdata_i[mem_pkg::ADDR_W-1:0];
        REG_DST: dst_base_o <= cfg_wdata_i[mem_pkg::ADDR_W-1:0];
        REG_KEY: key_o      <= cfg_wdata_i;
        default: ;
      endcase
    end
  end

  // One-cycle start, the cycle after the write
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      start_o <= 1'b0;
    end else begin
      start_o <= cfg_wr && (cfg_addr_i == REG_START);
    end
  end

endmodule

// ==== logic/mem_pkg.sv ====
package mem_pkg;

  // Byte address width of the memory port
  localparam int ADDR_W = 32;

  // Byte stride between consecutive 32-bit words
  localparam int WORD_BYTES = 4;

endpackage

// ==== logic/crypt_pkg.sv ====
package crypt_pkg;

  // Word width seen by the engine and the controller
  localparam int DATA_W = 32;

  // Run sequencing states of the controller
  typedef enum logic [3:0] {
    IDLE              = 4'd0,
    STARTING          = 4'd1,
    REQUEST_DATA      = 4'd2,
    REQUEST_DATA_WAIT = 4'd3,
    WORKING           = 4'd4,
    SEND_DATA         = 4'd5,
    SEND_DATA_WAIT    = 4'd6,
    MEMORY_WRITE_WAIT = 4'd7,
    FINISHED          = 4'd8
  } crypt_state_t;

endpackage
